// File: all.f
rtl/lsu_pkg.sv
rtl/dual_port_ram.sv
rtl/store_data_aligner.sv
rtl/load_data_translator.sv
rtl/lsu_ctrl.sv
rtl/lsu_top.sv
dv/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb
  import lsu_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam logic [31:0] SEED = 32'h51b0_ebae;
  // requests per test with fill writes counted as requests
  localparam int N_FILL      = 256 + 16;
  localparam int N_TRANSLATE = 24;
  localparam int N_STORE     = 48;
  localparam int N_MISALIGN  = 11;
  localparam int N_STREAM    = 32;
  localparam int N_STALL     = 64;
  localparam int WATCHDOG_CYCLES =
    10 * (N_FILL + N_TRANSLATE + N_STORE + N_MISALIGN + N_STREAM + N_STALL);

  logic                   clk = 1'b0;
  logic                   resetn;
  logic                   req_valid;
  logic                   req_ready;
  lsu_req_t               req;
  logic                   resp_valid;
  logic                   resp_ready = 1'b1;
  lsu_resp_t              resp;
  logic                   fill_valid;
  logic [WORD_ADDR_W-1:0] fill_addr;
  logic [DATA_W-1:0]      fill_data;

  // reference memory and expected response queue
  logic [DATA_W-1:0] ref_mem [2**WORD_ADDR_W];
  lsu_resp_t         exp_q[$];
  int                cyc_q[$];
  lsu_resp_t         exp_head = '0;
  logic              exp_avail = 1'b0;
  int                exp_cycle = 0;
  int                cycle_cnt = 0;
  logic              resp_pending = 1'b0;
  logic              lat_check;
  logic              stall_mode;
  logic              ready_next;
  int                err_count = 0;
  int                tests_done;

  lsu_top dut_i (
    .clk        (clk),
    .resetn     (resetn),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .fill_valid (fill_valid),
    .fill_addr  (fill_addr),
    .fill_data  (fill_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // random stalls on the response side
  always @(posedge clk)
  begin
    ready_next = stall_mode ? 1'($urandom) : 1'b1;
    #1;
    resp_ready = ready_next;
  end

  function automatic void log_failure(string msg);
    err_count++;
    $display("%s", msg);
  endfunction

  function automatic logic [DATA_W-1:0] fill_pattern(logic [7:0] a);
    return {a, a ^ 8'ha5, ~a, a * 8'd7};
  endfunction

  function automatic logic is_misaligned(access_size_e size, logic [1:0] off);
    return ((size == size_half) && off[0]) || ((size == size_word) && (off != 2'b00));
  endfunction

  // big-endian field pick where byte offset 0 is bits 31:24
  function automatic logic [DATA_W-1:0] extract_load(logic [DATA_W-1:0] w,
    access_size_e size, logic sign_ext, logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    int          o;
    o = int'(off);
    case (size)
      size_byte:
      begin
        b = w[31-8*o -: 8];
        return (sign_ext && b[7]) ? {24'hff_ffff, b} : {24'h0, b};
      end
      size_half:
      begin
        h = {w[31-8*o -: 8], w[23-8*o -: 8]};
        return (sign_ext && h[15]) ? {16'hffff, h} : {16'h0, h};
      end
      default: return w;
    endcase
  endfunction

  function automatic lsu_resp_t expected_resp(lsu_req_t r);
    lsu_resp_t e;
    e.op    = r.op;
    e.error = is_misaligned(r.size, r.addr[1:0]);
    e.rdata = '0;
    if ((r.op == op_load) && !e.error)
    begin
      e.rdata = extract_load(ref_mem[r.addr[BYTE_ADDR_W-1:2]], r.size, r.sign_ext, r.addr[1:0]);
    end
    return e;
  endfunction

  function automatic void apply_store(lsu_req_t r);
    logic [DATA_W-1:0] w;
    int                o;
    if ((r.op != op_store) || is_misaligned(r.size, r.addr[1:0]))
    begin
      return;
    end
    w = ref_mem[r.addr[BYTE_ADDR_W-1:2]];
    o = int'(r.addr[1:0]);
    case (r.size)
      size_byte: w[31-8*o -: 8] = r.wdata[7:0];
      size_half: w[31-8*o -: 16] = r.wdata[15:0];
      default:   w = r.wdata;
    endcase
    ref_mem[r.addr[BYTE_ADDR_W-1:2]] = w;
  endfunction

  // model runs on the falling edge ahead of the transfer edge
  always @(negedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (!resetn)
    begin
      resp_pending = 1'b0;
    end
    else
    begin
      if (resp_pending && (exp_q.size() > 0))
      begin
        void'(exp_q.pop_front());
        void'(cyc_q.pop_front());
      end
      resp_pending = resp_valid && resp_ready;
      if (req_valid && req_ready)
      begin
        exp_q.push_back(expected_resp(req));
        cyc_q.push_back(cycle_cnt);
        apply_store(req);
      end
      if (fill_valid)
      begin
        ref_mem[fill_addr] = fill_data;
      end
    end
    exp_avail = (exp_q.size() > 0);
    if (exp_avail)
    begin
      exp_head  = exp_q[0];
      exp_cycle = cyc_q[0];
    end
  end

  a_reset_state: assert property (@(posedge clk) $rose(resetn) |-> req_ready && !resp_valid)
    else log_failure("req_ready low or resp_valid high when reset was released");
  a_resp_known: assert property (@(posedge clk) disable iff (!resetn)
    resp_valid && resp_ready |-> exp_avail)
    else log_failure("response returned with no request outstanding");
  a_resp_op: assert property (@(posedge clk) disable iff (!resetn)
    resp_valid && resp_ready && exp_avail |-> resp.op == exp_head.op)
    else log_failure($sformatf("Mismatch resp.op: got %h expected %h",
      $sampled(resp.op), exp_head.op));
  a_resp_error: assert property (@(posedge clk) disable iff (!resetn)
    resp_valid && resp_ready && exp_avail |-> resp.error == exp_head.error)
    else log_failure($sformatf("Mismatch resp.error: got %h expected %h",
      $sampled(resp.error), exp_head.error));
  a_resp_rdata: assert property (@(posedge clk) disable iff (!resetn)
    resp_valid && resp_ready && exp_avail |-> resp.rdata == exp_head.rdata)
    else log_failure($sformatf("Mismatch resp.rdata: got %h expected %h",
      $sampled(resp.rdata), exp_head.rdata));
  a_latency: assert property (@(posedge clk) disable iff (!resetn)
    resp_valid && resp_ready && exp_avail && lat_check |-> cycle_cnt - exp_cycle == 2)
    else log_failure($sformatf("response came %0d cycles after acceptance instead of 2",
      cycle_cnt - exp_cycle));
  a_stream_accept: assert property (@(posedge clk) disable iff (!resetn)
    lat_check && req_valid |-> req_ready)
    else log_failure("back-to-back request was not accepted");
  a_resp_hold: assert property (@(posedge clk) disable iff (!resetn)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else log_failure("resp dropped or changed while stalled");

  function automatic lsu_req_t make_req(lsu_op_e op, access_size_e size, logic sign_ext,
    logic [BYTE_ADDR_W-1:0] addr, logic [DATA_W-1:0] wdata);
    lsu_req_t r;
    r.op       = op;
    r.size     = size;
    r.sign_ext = sign_ext;
    r.addr     = addr;
    r.wdata    = wdata;
    return r;
  endfunction

  function automatic lsu_req_t random_req();
    lsu_op_e      op;
    access_size_e size;
    op = ($urandom % 2 == 0) ? op_load : op_store;
    case (2'($urandom))
      2'd0:    size = size_word;
      2'd1:    size = size_half;
      default: size = size_byte;
    endcase
    return make_req(op, size, 1'($urandom), {2'b00, 6'($urandom), 2'($urandom)}, $urandom);
  endfunction

  // tasks start and end 1 ns after a rising edge
  task automatic send_req(lsu_req_t r);
    logic taken;
    req       = r;
    req_valid = 1'b1;
    taken     = 1'b0;
    while (!taken)
    begin
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
  endtask

  task automatic fill_word(logic [WORD_ADDR_W-1:0] addr, logic [DATA_W-1:0] data);
    fill_valid = 1'b1;
    fill_addr  = addr;
    fill_data  = data;
    @(posedge clk);
    #1;
    fill_valid = 1'b0;
  endtask

  task automatic drain_responses();
    while ((exp_q.size() != 0) || resp_valid)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic finish_test(string name);
    drain_responses();
    tests_done++;
    $display("test %0s finished, %0d failed checks so far", name, err_count);
  endtask

  task automatic fill_and_read_back();
    for (int i = 0; i < 2**WORD_ADDR_W; i++)
    begin
      fill_word(8'(i), fill_pattern(8'(i)));
    end
    for (int i = 0; i < 16; i++)
    begin
      send_req(make_req(op_load, size_word, 1'b0, {8'(i * 16 + 3), 2'b00}, '0));
    end
    finish_test("reset_and_fill");
  endtask

  task automatic translate_loads();
    logic [7:0] word;
    for (int w = 0; w < 2; w++)
    begin
      // one word with positive and negative bytes and halves each
      word = (w == 0) ? 8'h21 : 8'hc7;
      for (int s = 0; s < 2; s++)
      begin
        for (int o = 0; o < 4; o++)
        begin
          send_req(make_req(op_load, size_byte, 1'(s), {word, 2'(o)}, '0));
        end
        send_req(make_req(op_load, size_half, 1'(s), {word, 2'b00}, '0));
        send_req(make_req(op_load, size_half, 1'(s), {word, 2'b10}, '0));
      end
    end
    finish_test("load_translation");
  endtask

  task automatic store_partial_words();
    logic [7:0]   word;
    logic [1:0]   off;
    access_size_e size;
    for (int i = 0; i < N_STORE / 2; i++)
    begin
      word = 8'(16 + (i % 16));
      off  = 2'($urandom);
      size = size_byte;
      if ($urandom % 2 == 0)
      begin
        size   = size_half;
        off[0] = 1'b0;
      end
      send_req(make_req(op_store, size, 1'b0, {word, off}, $urandom));
      send_req(make_req(op_load, size_word, 1'b0, {word, 2'b00}, '0));
    end
    finish_test("stores");
  endtask

  task automatic access_misaligned();
    for (int o = 1; o < 4; o++)
    begin
      send_req(make_req(op_load, size_word, 1'b0, {8'd40, 2'(o)}, '0));
      send_req(make_req(op_store, size_word, 1'b0, {8'd40, 2'(o)}, $urandom));
      if (o != 2)
      begin
        send_req(make_req(op_load, size_half, 1'b1, {8'd40, 2'(o)}, '0));
        send_req(make_req(op_store, size_half, 1'b0, {8'd40, 2'(o)}, $urandom));
      end
    end
    send_req(make_req(op_load, size_word, 1'b0, {8'd40, 2'b00}, '0));
    finish_test("misaligned");
  endtask

  task automatic stream_and_stall();
    lat_check = 1'b1;
    for (int i = 0; i < N_STREAM; i++)
    begin
      send_req(random_req());
    end
    drain_responses();
    lat_check  = 1'b0;
    stall_mode = 1'b1;
    for (int i = 0; i < N_STALL; i++)
    begin
      if ($urandom % 4 == 0)
      begin
        @(posedge clk);
        #1;
      end
      send_req(random_req());
    end
    drain_responses();
    stall_mode = 1'b0;
    finish_test("timing_and_backpressure");
  endtask

  initial
  begin
    void'($urandom(SEED));
    resetn     = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    fill_valid = 1'b0;
    fill_addr  = '0;
    fill_data  = '0;
    lat_check  = 1'b0;
    stall_mode = 1'b0;
    tests_done = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    resetn = 1'b1;
    fill_and_read_back();
    translate_loads();
    store_partial_words();
    access_misaligned();
    stream_and_stall();
    $display("%0d tests run, %0d checks failed", tests_done, err_count);
    if (err_count == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  lsu_req_t               req,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output lsu_resp_t              resp,
  input  logic                   fill_valid,
  input  logic [WORD_ADDR_W-1:0] fill_addr,
  input  logic [DATA_W-1:0]      fill_data
);

  store_lanes_t           aligned_lanes;
  logic                   misaligned;
  logic                   a_rd_en;
  logic                   a_wr_en;
  logic [WORD_ADDR_W-1:0] a_addr;
  store_lanes_t           a_wr;
  logic [DATA_W-1:0]      a_rdata;
  logic [DATA_W-1:0]      load_result;
  load_key_t              key;

  lsu_ctrl u_ctrl (
    .clk         (clk),
    .resetn      (resetn),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req         (req),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp        (resp),
    .store_lanes (aligned_lanes),
    .misaligned  (misaligned),
    .a_rd_en     (a_rd_en),
    .a_wr_en     (a_wr_en),
    .a_addr      (a_addr),
    .a_wr        (a_wr),
    .load_result (load_result),
    .key         (key)
  );

  // aligner works on the request as presented
  store_data_aligner u_aligner (
    .size       (req.size),
    .byte_off   (req.addr[1:0]),
    .wdata      (req.wdata),
    .lanes      (aligned_lanes),
    .misaligned (misaligned)
  );

  dual_port_ram u_ram (
    .clk     (clk),
    .a_rd_en (a_rd_en),
    .a_wr_en (a_wr_en),
    .a_addr  (a_addr),
    .a_wr    (a_wr),
    .a_rdata (a_rdata),
    .b_wr_en (fill_valid),
    .b_addr  (fill_addr),
    .b_wdata (fill_data)
  );

  load_data_translator u_translator (
    .rdata  (a_rdata),
    .key    (key),
    .result (load_result)
  );

endmodule

`default_nettype wire

// File: rtl/lsu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   resetn,
  // request side
  input  logic                   req_valid,
  output logic                   req_ready,
  input  lsu_req_t               req,
  // response side
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output lsu_resp_t              resp,
  // from the store aligner
  input  store_lanes_t           store_lanes,
  input  logic                   misaligned,
  // RAM port A
  output logic                   a_rd_en,
  output logic                   a_wr_en,
  output logic [WORD_ADDR_W-1:0] a_addr,
  output store_lanes_t           a_wr,
  // translator path
  input  logic [DATA_W-1:0]      load_result,
  output load_key_t              key
);

  logic key_valid;
  logic resp_free;
  logic key_advance;
  logic accept;

  // response register can take a new entry this cycle
  assign resp_free   = !resp_valid || resp_ready;
  assign key_advance = key_valid && resp_free;
  assign req_ready   = !key_valid || resp_free;
  assign accept      = req_valid && req_ready;

  // RAM access issued at the acceptance edge
  assign a_addr  = req.addr[BYTE_ADDR_W-1:2];
  assign a_rd_en = accept && (req.op == op_load) && !misaligned;
  assign a_wr_en = accept && (req.op == op_store) && !misaligned;

  // lanes are blanked unless the write actually goes out
  assign a_wr.data    = store_lanes.data;
  assign a_wr.byte_en = a_wr_en ? store_lanes.byte_en : '0;

  // key stage, holds size and offset until the read word is back
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      key_valid <= 1'b0;
    end
    else if (req_ready)
    begin
      key_valid <= req_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      key.op       <= req.op;
      key.size     <= req.size;
      key.sign_ext <= req.sign_ext;
      key.byte_off <= req.addr[1:0];
      key.error    <= misaligned;
    end
  end

  // response register
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      resp_valid <= 1'b0;
    end
    else if (resp_free)
    begin
      resp_valid <= key_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (key_advance)
    begin
      resp.op    <= key.op;
      resp.error <= key.error;
      // stores and faulted loads return zero
      if ((key.op == op_load) && !key.error)
      begin
        resp.rdata <= load_result;
      end
      else
      begin
        resp.rdata <= '0;
      end
    end
  end

  a_resp_stable: assert property (
    @(posedge clk) disable iff (!resetn)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp)
  ) else $error("resp changed while stalled");

  // a stalled key stage must not be overwritten by a new request
  a_key_hold: assert property (
    @(posedge clk) disable iff (!resetn)
    key_valid && !resp_free |=> key_valid && $stable(key)
  ) else $error("request accepted while key stage stalled");

endmodule

`default_nettype wire

// File: rtl/load_data_translator.sv
`timescale 1ns/100ps
`default_nettype none

module load_data_translator
  import lsu_pkg::*;
(
  input  logic [DATA_W-1:0] rdata,
  input  load_key_t         key,
  output logic [DATA_W-1:0] result
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        fill_bit;

  // big-endian byte pick, offset 0 is the top byte
  always_comb
  begin
    case (key.byte_off)
      2'b00:   byte_sel = rdata[31:24];
      2'b01:   byte_sel = rdata[23:16];
      2'b10:   byte_sel = rdata[15:8];
      default: byte_sel = rdata[7:0];
    endcase
  end

  // only offset bit 1 matters for halfwords
  always_comb
  begin
    if (key.byte_off[1])
    begin
      half_sel = rdata[15:0];
    end
    else
    begin
      half_sel = rdata[31:16];
    end
  end

  always_comb
  begin
    case (key.size)
      size_byte:
      begin
        fill_bit = key.sign_ext & byte_sel[7];
        result   = {{(DATA_W-8){fill_bit}}, byte_sel};
      end
      size_half:
      begin
        fill_bit = key.sign_ext & half_sel[15];
        result   = {{(DATA_W-16){fill_bit}}, half_sel};
      end
      default:
      begin
        // word passes straight through
        fill_bit = 1'b0;
        result   = rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/store_data_aligner.sv
`timescale 1ns/100ps
`default_nettype none

module store_data_aligner
  import lsu_pkg::*;
(
  input  access_size_e      size,
  input  logic [1:0]        byte_off,
  input  logic [DATA_W-1:0] wdata,
  output store_lanes_t      lanes,
  output logic              misaligned
);

  localparam int HALVES_PER_WORD = BYTES_PER_WORD / 2;

  logic [1:0] lane_idx;

  // offset 0 maps to lane 3, bits 31:24
  assign lane_idx = 2'd3 - byte_off;

  always_comb
  begin
    lanes.byte_en = '0;
    lanes.data    = wdata;
    misaligned    = 1'b0;
    case (size)
      size_byte:
      begin
        // byte copied to every lane, one enable set
        lanes.data              = {BYTES_PER_WORD{wdata[7:0]}};
        lanes.byte_en[lane_idx] = 1'b1;
      end
      size_half:
      begin
        lanes.data = {HALVES_PER_WORD{wdata[15:0]}};
        if (byte_off[1])
        begin
          lanes.byte_en = 4'b0011;
        end
        else
        begin
          lanes.byte_en = 4'b1100;
        end
        // odd offset splits the halfword
        misaligned = byte_off[0];
      end
      default:
      begin
        lanes.byte_en = '1;
        misaligned    = |byte_off;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/dual_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dual_port_ram
  import lsu_pkg::*;
(
  input  logic                   clk,
  // port A for loads and stores
  input  logic                   a_rd_en,
  input  logic                   a_wr_en,
  input  logic [WORD_ADDR_W-1:0] a_addr,
  input  store_lanes_t           a_wr,
  output logic [DATA_W-1:0]      a_rdata,
  // port B for fills
  input  logic                   b_wr_en,
  input  logic [WORD_ADDR_W-1:0] b_addr,
  input  logic [DATA_W-1:0]      b_wdata
);

  logic [DATA_W-1:0] mem [2**WORD_ADDR_W];

  always_ff @(posedge clk)
  begin
    // full word fill on port B
    if (b_wr_en)
    begin
      mem[b_addr] <= b_wdata;
    end
    // byte-enabled write on port A
    if (a_wr_en)
    begin
      for (int i = 0; i < BYTES_PER_WORD; i++)
      begin
        if (a_wr.byte_en[i])
        begin
          mem[a_addr][i*8 +: 8] <= a_wr.data[i*8 +: 8];
        end
      end
    end
  end

  // registered read returns the old word on a same-cycle write
  // output holds while a_rd_en is low
  always_ff @(posedge clk)
  begin
    if (a_rd_en)
    begin
      a_rdata <= mem[a_addr];
    end
  end

  // fill and store must never hit the same word together
  a_no_write_collision: assert property (
    @(posedge clk) !(a_wr_en && b_wr_en && (a_addr == b_addr))
  ) else $error("fill and store to word %h in the same cycle", a_addr);

endmodule

`default_nettype wire

// File: rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int DATA_W         = 32;
  localparam int BYTES_PER_WORD = 4;
  localparam int WORD_ADDR_W    = 8;
  localparam int BYTE_ADDR_W    = 10;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } lsu_op_e;

  // encodings match the processor's load/store size field
  typedef enum logic [1:0] {
    size_word = 2'b00,
    size_half = 2'b01,
    size_byte = 2'b11
  } access_size_e;

  typedef struct packed {
    lsu_op_e                op;
    access_size_e           size;
    logic                   sign_ext;
    logic [BYTE_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      wdata;
  } lsu_req_t;

  typedef struct packed {
    logic              op;
    logic              error;
    logic [DATA_W-1:0] rdata;
  } lsu_resp_t;

  // access in flight between RAM read and response register
  typedef struct packed {
    logic       op;
    logic [1:0] size;
    logic       sign_ext;
    logic [1:0] byte_off;
    logic       error;
  } load_key_t;

  // lane 3 is bits 31:24, the big-endian byte 0
  typedef struct packed {
    logic [BYTES_PER_WORD-1:0] byte_en;
    logic [DATA_W-1:0]         data;
  } store_lanes_t;

endpackage

`default_nettype wire
